// ==== tb.f ====
+incdir+hw
hw/radio_types_pkg.sv
hw/settings_pkg.sv
hw/db_settings_regs.sv
hw/rx_frontend.sv
hw/anc_tx_combiner.sv
hw/radio_fe_core.sv
sim/radio_fe_core_assert.sv
sim/radio_fe_core_tb.sv

// ==== sim/radio_fe_core_tb.sv ====
// ---------------------------------------
// directed tests for the two-slice radio front end
// expected samples come from a behavioral model of the rules
// ---------------------------------------
`timescale 1ns/100ps
`include "radio_fe_params.svh"

module radio_fe_core_tb
   import settings_pkg::*;
   import radio_types_pkg::*;
();

   localparam int NS         = `NUM_DBOARDS;
   localparam int WAIT_LIMIT = 10;
   localparam int STREAM_LEN = 40;            // at most 60
   localparam longint UNITY  = 1 << `ANC_FRAC;

   logic                       radio_clk;
   logic                       i_rst;
   set_bus_t  [NS-1:0]         set_bus;
   iq_t       [NS-1:0]         rx_in;
   iq_t       [NS-1:0]         tx_in;
   iq_t       [NS-1:0]         tx_out;
   set_data_t [NS-1:0]         gpio_out;
   set_data_t [NS-1:0]         gpio_ddr;
   set_data_t [NS-1:0]         misc_out;
   logic      [NS-1:0][2:0]    radio_led;

   // model copy of each slice's configuration
   iq_t    cfg_offset [NS];
   logic   cfg_swap   [NS];
   logic   cfg_en     [NS];
   scale_t cfg_scale  [NS];

   int  seed;
   int  errors;
   int  checks;
   iq_t rx_directed [$];   // fed before random samples

   radio_fe_core i_radio_fe_core (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_set         (set_bus),
      .i_rx          (rx_in),
      .i_tx          (tx_in),
      .o_tx          (tx_out),
      .o_db_gpio_out (gpio_out),
      .o_db_gpio_ddr (gpio_ddr),
      .o_misc_out    (misc_out),
      .o_radio_led   (radio_led)
   );

   always #4 radio_clk = ~radio_clk;

   // ---------------------------------------
   // drive and compare helpers
   // ---------------------------------------
   task automatic tick();
      @(negedge radio_clk);
   endtask

   task automatic write_set(input int s, input int addr, input set_data_t data);
      set_bus[s].stb  = 1'b1;
      set_bus[s].addr = set_addr_t'(addr);
      set_bus[s].data = data;
      tick();
      set_bus[s] = '0;
   endtask

   task automatic check_iq(input iq_t got, input iq_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got i=%0d q=%0d, expected i=%0d q=%0d",
                  $time, msg, got.i, got.q, exp.i, exp.q);
      end
   endtask

   task automatic check_word(input set_data_t got, input set_data_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_led(input logic [2:0] got, input logic [2:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before)
         $display("test %-12s ok", name);
      else
         $display("test %-12s %0d errors", name, errors - errors_before);
   endtask

   // ---------------------------------------
   // reference model
   // ---------------------------------------
   function automatic sample_t clamp16(input longint v);
      sample_t r;
      if (v > 32767)
         r = 16'sh7fff;
      else if (v < -32768)
         r = 16'sh8000;
      else
         r = sample_t'(v);
      return r;
   endfunction

   // division that rounds toward minus infinity
   function automatic longint floor_rescale(input longint p);
      longint q;
      q = p / UNITY;
      if (p < 0 && p % UNITY != 0)
         q = q - 1;
      return q;
   endfunction

   function automatic iq_t expected_anc(input int s, input iq_t rx);
      iq_t c;
      iq_t r;
      c.i = clamp16(longint'(rx.i) - longint'(cfg_offset[s].i));
      c.q = clamp16(longint'(rx.q) - longint'(cfg_offset[s].q));
      if (cfg_swap[s])
         c = {c.q, c.i};
      r.i = clamp16(-floor_rescale(longint'(c.i) * longint'(cfg_scale[s])));
      r.q = clamp16(-floor_rescale(longint'(c.q) * longint'(cfg_scale[s])));
      return r;
   endfunction

   function automatic iq_t make_iq(input int i, input int q);
      iq_t v;
      v.i = sample_t'(i);
      v.q = sample_t'(q);
      return v;
   endfunction

   task automatic configure(input int s, input iq_t offset, input logic swap,
                            input logic en, input scale_t scale);
      write_set(s, `SR_RX_FE_BASE, offset);
      write_set(s, `SR_RX_FE_BASE + 1, {31'd0, swap});
      write_set(s, `SR_DB_BASE + 4, {15'd0, en, scale});
      cfg_offset[s] = offset;
      cfg_swap[s]   = swap;
      cfg_en[s]     = en;
      cfg_scale[s]  = scale;
   endtask

   // polls one pin, counting the write cycle itself
   task automatic wait_gpio_out(input int s, input set_data_t exp);
      int cycles;
      cycles = 1;
      while (gpio_out[s] !== exp && cycles < WAIT_LIMIT) begin
         tick();
         cycles++;
      end
      if (gpio_out[s] !== exp) begin
         errors++;
         $display("timeout: gpio_out of slice %0d never showed %h", s, exp);
      end else if (cycles != 2) begin
         errors++;
         $display("gpio_out of slice %0d took %0d cycles instead of 2", s, cycles);
      end
   endtask

   // both slices at once, latency from each slice's en
   task automatic run_stream(input int n);
      iq_t exp_hist [NS][64];
      int  lat [NS];
      iq_t rxv;
      iq_t txv;
      for (int s = 0; s < NS; s++)
         lat[s] = cfg_en[s] ? 4 : 2;
      for (int c = 0; c < n + 4; c++) begin
         for (int s = 0; s < NS; s++) begin
            if (c >= lat[s] && c - lat[s] < n)
               check_iq(tx_out[s], exp_hist[s][c - lat[s]],
                        $sformatf("slice %0d sample %0d", s, c - lat[s]));
            if (c < n) begin
               rxv = (c < rx_directed.size()) ? rx_directed[c] : iq_t'($random(seed));
               txv = iq_t'($random(seed));
               rx_in[s] = rxv;
               tx_in[s] = txv;
               exp_hist[s][c] = cfg_en[s] ? expected_anc(s, rxv) : txv;
            end else begin
               rx_in[s] = '0;
               tx_in[s] = '0;
            end
         end
         tick();
      end
   endtask

   // ---------------------------------------
   // tests
   // ---------------------------------------
   task automatic test_reset();
      for (int s = 0; s < NS; s++) begin
         check_word(gpio_out[s], '0, $sformatf("slice %0d gpio_out after reset", s));
         check_word(gpio_ddr[s], '0, $sformatf("slice %0d gpio_ddr after reset", s));
         check_word(misc_out[s], '0, $sformatf("slice %0d misc_out after reset", s));
         check_led(radio_led[s], '0, $sformatf("slice %0d leds after reset", s));
         check_iq(tx_out[s], '0, $sformatf("slice %0d o_tx after reset", s));
      end
      tick();
      for (int s = 0; s < NS; s++)
         check_iq(tx_out[s], '0, $sformatf("slice %0d o_tx second cycle", s));
   endtask

   task automatic test_db_regs();
      set_data_t v [NS][4];
      for (int s = 0; s < NS; s++)
         for (int k = 0; k < 4; k++)
            v[s][k] = '0;
      for (int s = 0; s < NS; s++) begin
         for (int k = 0; k < 4; k++)
            v[s][k] = $random(seed);
         write_set(s, `SR_DB_BASE, v[s][0]);
         wait_gpio_out(s, v[s][0]);
         write_set(s, `SR_DB_BASE + 1, v[s][1]);
         write_set(s, `SR_DB_BASE + 2, v[s][2]);
         write_set(s, `SR_DB_BASE + 3, v[s][3]);
         write_set(s, `SR_DB_BASE - 1, 32'hffff_ffff);   // just outside the range
         write_set(s, `SR_DB_BASE + 5, 32'hffff_ffff);
         tick();
         tick();
         for (int t = 0; t < NS; t++) begin
            check_word(gpio_out[t], v[t][0], $sformatf("slice %0d gpio_out", t));
            check_word(gpio_ddr[t], v[t][1], $sformatf("slice %0d gpio_ddr", t));
            check_word(misc_out[t], v[t][2], $sformatf("slice %0d misc_out", t));
            check_led(radio_led[t], v[t][3][2:0], $sformatf("slice %0d leds", t));
         end
      end
   endtask

   task automatic test_anc_unity();
      for (int s = 0; s < NS; s++)
         configure(s, '0, 1'b0, 1'b1, scale_t'(16384));
      rx_directed.delete();
      rx_directed.push_back(make_iq(-32768, -32768));
      rx_directed.push_back(make_iq(32767, -32767));
      rx_directed.push_back(make_iq(0, 1));
      rx_directed.push_back(make_iq(-1, 12345));
      run_stream(STREAM_LEN);
   endtask

   task automatic test_anc_full();
      configure(0, make_iq(1000, -2000), 1'b1, 1'b1, scale_t'(-20000));
      configure(1, make_iq(-300, 700), 1'b0, 1'b1, scale_t'(30000));
      rx_directed.delete();
      rx_directed.push_back(make_iq(-32768, 32767));   // both stages saturate
      rx_directed.push_back(make_iq(32767, -32768));
      rx_directed.push_back(make_iq(-31000, 31000));
      rx_directed.push_back(make_iq(0, 0));
      rx_directed.push_back(make_iq(1, -1));
      rx_directed.push_back(make_iq(-1, 1));
      run_stream(STREAM_LEN);
   endtask

   initial begin
      int e0;
      radio_clk = 1'b0;
      i_rst     = 1'b1;
      set_bus   = '0;
      rx_in     = '0;
      tx_in     = '0;
      seed      = 32'hdbc5_967f;
      errors    = 0;
      checks    = 0;
      for (int s = 0; s < NS; s++) begin
         cfg_offset[s] = '0;
         cfg_swap[s]   = 1'b0;
         cfg_en[s]     = 1'b0;
         cfg_scale[s]  = '0;
      end
      repeat (2) tick();
      i_rst = 1'b0;

      e0 = errors;
      test_reset();
      report_test("reset", e0);
      e0 = errors;
      test_db_regs();
      report_test("db_regs", e0);
      e0 = errors;
      rx_directed.delete();
      run_stream(STREAM_LEN);   // ANC still off from reset
      report_test("anc_off", e0);
      e0 = errors;
      test_anc_unity();
      report_test("anc_unity", e0);
      e0 = errors;
      test_anc_full();
      report_test("anc_full", e0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== sim/radio_fe_core_assert.sv ====
// ---------------------------------------
// output checks for the tx combiner, bound to every instance
// bypass check holds only while en stays low
// ---------------------------------------
`timescale 1ns/100ps

module radio_fe_core_assert
   import settings_pkg::*;
   import radio_types_pkg::*;
(
   input logic      radio_clk,
   input logic      i_rst,
   input anc_ctrl_t i_anc_ctrl,
   input iq_t       i_tx,
   input iq_t       o_tx
);

   // cleared by every reset cycle
   a_reset_clears: assert property (@(posedge radio_clk) i_rst |=> (o_tx == '0))
      else $error("o_tx not zero after a reset cycle");

   // host delay stage was cleared too, so one more zero cycle
   a_reset_second: assert property (@(posedge radio_clk) $fell(i_rst) |-> ##1 (o_tx == '0))
      else $error("o_tx not zero in the second cycle after reset");

   // ---------------------------------------
   // bypass path
   // ---------------------------------------
   property p_bypass;
      @(posedge radio_clk) disable iff (i_rst)
         (!$past(i_rst) && !$past(i_rst, 2) && !$past(i_anc_ctrl.en, 2))
            |-> (o_tx == $past(i_tx, 2));
   endproperty

   a_bypass: assert property (p_bypass)
      else $error("o_tx differs from the host sample two cycles earlier");

endmodule

bind anc_tx_combiner radio_fe_core_assert i_radio_fe_core_assert (
   .radio_clk  (radio_clk),
   .i_rst      (i_rst),
   .i_anc_ctrl (i_anc_ctrl),
   .i_tx       (i_tx),
   .o_tx       (o_tx)
);

// ==== hw/radio_fe_core.sv ====
// ---------------------------------------
// radio clock datapath, one slice per daughterboard
// each slice has its own settings bus, samples every cycle
// control pins lag their register by one cycle
// ---------------------------------------
`timescale 1ns/100ps
`include "radio_fe_params.svh"

module radio_fe_core
   import settings_pkg::*;
   import radio_types_pkg::*;
(
   input  logic                                radio_clk,
   input  logic                                i_rst,
   // per-slice settings and samples
   input  set_bus_t  [`NUM_DBOARDS-1:0]        i_set,
   input  iq_t       [`NUM_DBOARDS-1:0]        i_rx,
   input  iq_t       [`NUM_DBOARDS-1:0]        i_tx,
   output iq_t       [`NUM_DBOARDS-1:0]        o_tx,
   // daughterboard pins
   output set_data_t [`NUM_DBOARDS-1:0]        o_db_gpio_out,
   output set_data_t [`NUM_DBOARDS-1:0]        o_db_gpio_ddr,
   output set_data_t [`NUM_DBOARDS-1:0]        o_misc_out,
   output logic      [`NUM_DBOARDS-1:0][2:0]   o_radio_led
);

   db_ctrl_t  db_ctrl  [`NUM_DBOARDS];
   anc_ctrl_t anc_ctrl [`NUM_DBOARDS];
   iq_t       rx_corr  [`NUM_DBOARDS];

   // ---------------------------------------
   // slices
   // ---------------------------------------
   for (genvar g = 0; g < `NUM_DBOARDS; g++) begin : gen_slice

      // control regs and rx front end share the slice bus
      db_settings_regs i_db_settings_regs (
         .radio_clk  (radio_clk),
         .i_rst      (i_rst),
         .i_set      (i_set[g]),
         .o_db_ctrl  (db_ctrl[g]),
         .o_anc_ctrl (anc_ctrl[g])
      );

      rx_frontend i_rx_frontend (
         .radio_clk (radio_clk),
         .i_rst     (i_rst),
         .i_set     (i_set[g]),
         .i_rx      (i_rx[g]),
         .o_rx      (rx_corr[g])
      );

      anc_tx_combiner i_anc_tx_combiner (
         .radio_clk  (radio_clk),
         .i_rst      (i_rst),
         .i_anc_ctrl (anc_ctrl[g]),
         .i_rx       (rx_corr[g]),
         .i_tx       (i_tx[g]),
         .o_tx       (o_tx[g])
      );

      // pin registers, one per slice
      always_ff @(posedge radio_clk) begin
         if (i_rst) begin
            o_db_gpio_out[g] <= '0;
            o_db_gpio_ddr[g] <= '0;
            o_misc_out[g]    <= '0;
            o_radio_led[g]   <= '0;
         end else begin
            o_db_gpio_out[g] <= db_ctrl[g].gpio_out;
            o_db_gpio_ddr[g] <= db_ctrl[g].gpio_ddr;
            o_misc_out[g]    <= db_ctrl[g].misc_out;
            o_radio_led[g]   <= db_ctrl[g].leds;
         end
      end

   end

endmodule

// ==== hw/anc_tx_combiner.sv ====
// ---------------------------------------
// tx source select: host data or -(rx * scale)
// both paths 2 cycles, en sampled with the sample in stage 1
// ---------------------------------------
`timescale 1ns/100ps
`include "radio_fe_params.svh"

module anc_tx_combiner
   import settings_pkg::*;
   import radio_types_pkg::*;
(
   input  logic      radio_clk,
   input  logic      i_rst,
   input  anc_ctrl_t i_anc_ctrl,
   input  iq_t       i_rx,        // corrected rx sample
   input  iq_t       i_tx,        // host tx sample
   output iq_t       o_tx
);

   // ---------------------------------------
   // stage 1: multiply and align host data
   // ---------------------------------------
   logic signed [31:0] prod_i;
   logic signed [31:0] prod_q;
   iq_t                tx_d1;     // host sample, one cycle behind
   logic               en_d1;     // source select travels with the data

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         prod_i <= '0;
         prod_q <= '0;
         tx_d1  <= '0;
         en_d1  <= 1'b0;
      end else begin
         prod_i <= $signed(i_rx.i) * $signed(i_anc_ctrl.scale);   // Q1.14 product
         prod_q <= $signed(i_rx.q) * $signed(i_anc_ctrl.scale);
         tx_d1  <= i_tx;
         en_d1  <= i_anc_ctrl.en;
      end
   end

   // ---------------------------------------
   // stage 2: rescale, invert, saturate, select
   // ---------------------------------------
   logic signed [31:0] inv_i;
   logic signed [31:0] inv_q;

   // floor shift then negate, 32 bits hold the full range
   always_comb begin
      inv_i = -(prod_i >>> `ANC_FRAC);
      inv_q = -(prod_q >>> `ANC_FRAC);
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_tx <= '0;
      end else if (en_d1) begin
         o_tx.i <= sat_sample(inv_i);   // -(-32768) clamps to 32767
         o_tx.q <= sat_sample(inv_q);
      end else begin
         o_tx <= tx_d1;
      end
   end

endmodule

// ==== hw/rx_frontend.sv ====
// ---------------------------------------
// rx DC-offset removal then optional I/Q swap
// 2 cycles, one sample per cycle, no stall
// ---------------------------------------
`timescale 1ns/100ps
`include "radio_fe_params.svh"

module rx_frontend
   import settings_pkg::*;
   import radio_types_pkg::*;
(
   input  logic     radio_clk,
   input  logic     i_rst,
   input  set_bus_t i_set,
   input  iq_t      i_rx,
   output iq_t      o_rx
);

   localparam set_addr_t ADDR_DC_OFFSET = set_addr_t'(`SR_RX_FE_BASE + 0);
   localparam set_addr_t ADDR_SWAP_IQ   = set_addr_t'(`SR_RX_FE_BASE + 1);

   iq_t  dc_offset;   // subtracted per component
   logic swap_iq;

   // ---------------------------------------
   // settings
   // ---------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         dc_offset <= '0;
         swap_iq   <= 1'b0;
      end else if (i_set.stb) begin
         if (i_set.addr == ADDR_DC_OFFSET)
            dc_offset <= i_set.data;   // i in 31..16, q in 15..0
         if (i_set.addr == ADDR_SWAP_IQ)
            swap_iq <= i_set.data[0];
      end
   end

   // ---------------------------------------
   // stage 1: offset removal
   // ---------------------------------------
   logic signed [31:0] diff_i;
   logic signed [31:0] diff_q;
   iq_t                corr;

   // widened so the difference never wraps
   always_comb begin
      diff_i = $signed(i_rx.i) - $signed(dc_offset.i);
      diff_q = $signed(i_rx.q) - $signed(dc_offset.q);
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         corr <= '0;
      end else begin
         corr.i <= sat_sample(diff_i);
         corr.q <= sat_sample(diff_q);
      end
   end

   // ---------------------------------------
   // stage 2: swap
   // ---------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx <= '0;
      end else if (swap_iq) begin
         o_rx.i <= corr.q;
         o_rx.q <= corr.i;
      end else begin
         o_rx <= corr;
      end
   end

endmodule

// ==== hw/db_settings_regs.sv ====
// ---------------------------------------
// daughterboard control registers, write only
// decodes SR_DB_BASE .. SR_DB_BASE+4, other addresses ignored
// ---------------------------------------
`timescale 1ns/100ps
`include "radio_fe_params.svh"

module db_settings_regs
   import settings_pkg::*;
(
   input  logic      radio_clk,
   input  logic      i_rst,
   input  set_bus_t  i_set,
   output db_ctrl_t  o_db_ctrl,
   output anc_ctrl_t o_anc_ctrl
);

   // ---------------------------------------
   // register map
   // ---------------------------------------
   localparam set_addr_t ADDR_GPIO_OUT = set_addr_t'(`SR_DB_BASE + 0);
   localparam set_addr_t ADDR_GPIO_DDR = set_addr_t'(`SR_DB_BASE + 1);
   localparam set_addr_t ADDR_MISC_OUT = set_addr_t'(`SR_DB_BASE + 2);
   localparam set_addr_t ADDR_LEDS     = set_addr_t'(`SR_DB_BASE + 3);
   localparam set_addr_t ADDR_ANC      = set_addr_t'(`SR_DB_BASE + 4);

   // ANC word layout
   localparam int ANC_EN_BIT = 16;

   db_ctrl_t  db_ctrl;
   anc_ctrl_t anc_ctrl;

   // ---------------------------------------
   // write decode
   // ---------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         db_ctrl  <= '0;
         anc_ctrl <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            ADDR_GPIO_OUT: begin
               db_ctrl.gpio_out <= i_set.data;
            end
            ADDR_GPIO_DDR: begin
               db_ctrl.gpio_ddr <= i_set.data;
            end
            ADDR_MISC_OUT: begin
               db_ctrl.misc_out <= i_set.data;
            end
            ADDR_LEDS: begin
               db_ctrl.leds <= i_set.data[2:0];   // upper bits dropped
            end
            ADDR_ANC: begin
               anc_ctrl.scale <= i_set.data[15:0];
               anc_ctrl.en    <= i_set.data[ANC_EN_BIT];
            end
            default: begin
               // not ours, rx_frontend shares this bus
            end
         endcase
      end
   end

   assign o_db_ctrl  = db_ctrl;
   assign o_anc_ctrl = anc_ctrl;

endmodule

// ==== hw/settings_pkg.sv ====
// ---------------------------------------
// settings bus and daughterboard control types
// the scale field borrows its type from radio_types_pkg
// ---------------------------------------
`include "radio_fe_params.svh"

package settings_pkg;

   typedef logic [`SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`SET_DATA_W-1:0] set_data_t;

   // one write per cycle with stb high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // ---------------------------------------
   // per-slice control outputs
   // ---------------------------------------
   typedef struct packed {
      set_data_t  gpio_out;
      set_data_t  gpio_ddr;    // 1 = output
      set_data_t  misc_out;
      logic [2:0] leds;        // {rx, txrx_tx, txrx_rx}
   } db_ctrl_t;

   // canceller control
   typedef struct packed {
      logic                    en;     // 0 = host tx data passes
      radio_types_pkg::scale_t scale;
   } anc_ctrl_t;

endpackage

// ==== hw/radio_types_pkg.sv ====
// ---------------------------------------
// sample types and the shared 16-bit saturation
// saturation input must fit in 32 signed bits
// ---------------------------------------
`include "radio_fe_params.svh"

package radio_types_pkg;

   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   // i in the upper half, q in the lower half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   typedef logic signed [`SAMPLE_W-1:0] scale_t;   // Q1.14, 16384 = 1.0

   // ---------------------------------------
   // saturation
   // ---------------------------------------
   localparam logic signed [31:0] SAMPLE_MAX = (32'sd1 <<< (`SAMPLE_W-1)) - 32'sd1;
   localparam logic signed [31:0] SAMPLE_MIN = -(32'sd1 <<< (`SAMPLE_W-1));

   // clamp a wide signed value into one sample
   function automatic sample_t sat_sample(input logic signed [31:0] x);
      sample_t res;
      if (x > SAMPLE_MAX)
         res = sample_t'(SAMPLE_MAX);
      else if (x < SAMPLE_MIN)
         res = sample_t'(SAMPLE_MIN);
      else
         res = sample_t'(x);
      return res;
   endfunction

endpackage

// ==== hw/radio_fe_params.svh ====
// ---------------------------------------
// global sizes and settings-bus bases for the radio front end
// settings addresses must stay below 256 (8-bit bus address)
// ---------------------------------------
`ifndef RADIO_FE_PARAMS_SVH
`define RADIO_FE_PARAMS_SVH

// slices
`define NUM_DBOARDS   2

// ---------------------------------------
// datapath widths
// ---------------------------------------
`define SAMPLE_W      16              // one I or Q component
`define SET_ADDR_W    8
`define SET_DATA_W    32

// ---------------------------------------
// settings bus register bases
// ---------------------------------------
`define SR_DB_BASE    160             // daughterboard control, 5 regs
`define SR_RX_FE_BASE (`SR_DB_BASE + 64)  // rx front end, 2 regs

// ---------------------------------------
// canceller fixed point
// ---------------------------------------
// scale is Q1.14, so the product is shifted back by this many bits
`define ANC_FRAC      14

`endif
